// File: src/eth_loop_macros.svh
// Fixed Ethernet loopback constants for frame timing, FIFO size and CRC, included by the RTL
`ifndef ETH_LOOP_MACROS_SVH
`define ETH_LOOP_MACROS_SVH

// Idle cycles that must separate two transmitted frames
`define ETH_IFG_BYTES 12

// Shortest legal frame on the wire, FCS included
`define ETH_MIN_FRAME_LEN 64

// FIFO address width, 11 bits gives 2048 bytes of storage
`define ETH_FIFO_ADDR_W 11

// CRC register preset at the first byte after the delimiter
`define ETH_CRC_INIT 32'hffff_ffff

// Remainder left over a good frame plus its FCS, in normal bit order
`define ETH_CRC_RESIDUE 32'hc704_dd7b

`endif

// File: src/eth_loop_pkg.sv
// Types shared by the receive decoder and the frame FIFO, referenced by scoped name
`default_nettype none

package eth_loop_pkg;

// How a received frame ended, reported alongside the frame_end pulse
typedef enum logic [1:0] {
    none     = 2'd0,  // No frame has finished since reset
    good     = 2'd1,
    bad_fcs  = 2'd2,  // FCS mismatch or a runt too short to hold an FCS
    rx_error = 2'd3   // The PHY raised gmii_rx_er inside the frame
} frame_status_e;

endpackage

`default_nettype wire

// File: src/eth_crc32.sv
// One-byte step of the reflected Ethernet CRC-32, used by both the receive and transmit paths
`default_nettype none

module eth_crc32 (
    input  wire logic [31:0] crc_in,
    input  wire logic [7:0]  data,
    output logic      [31:0] crc_out
);

// Reflected form of the 802.3 generator polynomial
localparam logic [31:0] poly = 32'hedb8_8320;

// Bits enter LSB first, matching the order they leave the MAC
always_comb begin
    crc_out = crc_in;
    for (int i = 0; i < 8; i++) begin
        if (crc_out[0] ^ data[i]) begin
            crc_out = (crc_out >> 1) ^ poly;
        end else begin
            crc_out = crc_out >> 1;
        end
    end
end

endmodule

`default_nettype wire

// File: src/gmii_rx_decode.sv
// GMII receive side that strips preamble and FCS, streams payload bytes and grades each frame
`default_nettype none
`include "eth_loop_macros.svh"

module gmii_rx_decode (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [7:0]             gmii_rxd,
    input  wire logic                   gmii_rx_dv,
    input  wire logic                   gmii_rx_er,
    output logic [7:0]                  wr_data,
    output logic                        wr_en,
    output logic                        frame_end,
    output eth_loop_pkg::frame_status_e frame_status,
    output logic                        rx_good_frame,
    output logic                        rx_bad_frame
);

logic [7:0]  rxd_q;
logic        rx_dv_q;
logic        rx_er_q;
logic        in_frame;
logic        err_seen;
logic [2:0]  byte_cnt;     // Saturates at 5, enough to tell a runt from a real frame
logic [7:0]  dly [4];
logic [31:0] crc;
logic [31:0] crc_next;
logic [31:0] crc_rev;
logic        frame_byte;

assign frame_byte = in_frame && rx_dv_q;

// With four bytes held back, each new byte pushes the oldest out as payload
assign wr_en   = frame_byte && (byte_cnt >= 3'd4);
assign wr_data = dly[3];

eth_crc32 crc_i (
    .crc_in(crc),
    .data(rxd_q),
    .crc_out(crc_next)
);

// The residue constant is written MSB first while the register shifts right
always_comb begin
    for (int i = 0; i < 32; i++) begin
        crc_rev[i] = crc[31 - i];
    end
end

always_ff @(posedge clk) begin
    rxd_q <= gmii_rxd;
    if (!in_frame) begin
        crc <= `ETH_CRC_INIT;  // Held at the preset until the delimiter shows up
    end else if (rx_dv_q) begin
        crc    <= crc_next;
        dly[0] <= rxd_q;
        dly[1] <= dly[0];
        dly[2] <= dly[1];
        dly[3] <= dly[2];
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rx_dv_q       <= 1'b0;
        rx_er_q       <= 1'b0;
        in_frame      <= 1'b0;
        err_seen      <= 1'b0;
        byte_cnt      <= 3'd0;
        frame_end     <= 1'b0;
        frame_status  <= eth_loop_pkg::none;
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
    end else begin
        rx_dv_q       <= gmii_rx_dv;
        rx_er_q       <= gmii_rx_er;
        frame_end     <= 1'b0;
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
        if (!in_frame) begin
            // Preamble bytes are skipped until the start-of-frame delimiter
            if (rx_dv_q && rxd_q == 8'hd5) begin
                in_frame <= 1'b1;
                err_seen <= 1'b0;
                byte_cnt <= 3'd0;
            end
        end else if (rx_dv_q) begin
            if (rx_er_q) begin
                err_seen <= 1'b1;
            end
            if (byte_cnt != 3'd5) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end else begin
            // Carrier dropped so the CRC now covers every byte, FCS included
            in_frame  <= 1'b0;
            frame_end <= 1'b1;
            if (err_seen) begin
                frame_status <= eth_loop_pkg::rx_error;
                rx_bad_frame <= 1'b1;
            end else if (byte_cnt != 3'd5 || crc_rev != `ETH_CRC_RESIDUE) begin
                frame_status <= eth_loop_pkg::bad_fcs;
                rx_bad_frame <= 1'b1;
            end else begin
                frame_status  <= eth_loop_pkg::good;
                rx_good_frame <= 1'b1;
            end
        end
    end
end

endmodule

`default_nettype wire

// File: src/frame_fifo.sv
// Store-and-forward byte FIFO that only exposes complete good frames to the transmit side
`default_nettype none

module frame_fifo #(
    parameter int addr_w = 11
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [7:0]                  wr_data,
    input  wire logic                        wr_en,
    input  wire logic                        frame_end,
    input  wire eth_loop_pkg::frame_status_e frame_status,
    output logic                             frame_ready,
    output logic [7:0]                       rd_data,
    output logic                             rd_last,
    input  wire logic                        rd_en,
    output logic                             fifo_overflow
);

localparam int depth = 2 ** addr_w;

// Each entry is a byte with its end-of-frame flag on top
logic [8:0]        mem [depth];
logic [addr_w:0]   wr_ptr;
logic [addr_w:0]   commit_ptr;   // End of the last committed frame
logic [addr_w:0]   rd_ptr;
logic [addr_w:0]   frame_cnt;
logic [addr_w:0]   last_ptr;
logic              drop;         // Set once a frame has overrun the storage
logic [7:0]        last_byte;
logic              full;
logic              commit;
logic              read_last;

// Same address with opposite wrap bits means the writer has lapped the reader
assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
              (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

assign commit    = frame_end && !drop && (frame_status == eth_loop_pkg::good);
assign read_last = rd_en && rd_last;
assign last_ptr  = wr_ptr - 1'b1;

assign frame_ready        = (frame_cnt != '0);
assign {rd_last, rd_data} = mem[rd_ptr[addr_w-1:0]];

always_ff @(posedge clk) begin
    if (wr_en && !full && !drop) begin
        mem[wr_ptr[addr_w-1:0]] <= {1'b0, wr_data};
        last_byte               <= wr_data;
    end else if (commit) begin
        // The end of a frame is only known afterwards, so its final byte is rewritten
        mem[last_ptr[addr_w-1:0]] <= {1'b1, last_byte};
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr        <= '0;
        commit_ptr    <= '0;
        rd_ptr        <= '0;
        frame_cnt     <= '0;
        drop          <= 1'b0;
        fifo_overflow <= 1'b0;
    end else begin
        fifo_overflow <= 1'b0;
        if (wr_en && !drop) begin
            if (full) begin
                drop <= 1'b1;  // Rest of this frame is thrown away
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
        if (frame_end) begin
            if (commit) begin
                commit_ptr <= wr_ptr;
            end else begin
                wr_ptr        <= commit_ptr;  // Rewind past the rejected bytes
                fifo_overflow <= drop;
            end
            drop <= 1'b0;
        end
        if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({commit, read_last})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: frame_cnt <= frame_cnt;
        endcase
    end
end

endmodule

`default_nettype wire

// File: src/gmii_tx_encode.sv
// GMII transmit side that frames stored payload with preamble, padding, FCS and the inter-frame gap
`default_nettype none
`include "eth_loop_macros.svh"

module gmii_tx_encode (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       frame_ready,
    input  wire logic [7:0] rd_data,
    input  wire logic       rd_last,
    output logic            rd_en,
    output logic [7:0]      gmii_txd,
    output logic            gmii_tx_en,
    output logic            gmii_tx_er
);

localparam logic [2:0] st_idle     = 3'd0;
localparam logic [2:0] st_preamble = 3'd1;
localparam logic [2:0] st_payload  = 3'd2;
localparam logic [2:0] st_pad      = 3'd3;
localparam logic [2:0] st_fcs      = 3'd4;
localparam logic [2:0] st_gap      = 3'd5;

// Payload plus pad must reach the minimum length less the four FCS bytes
localparam int min_payload = `ETH_MIN_FRAME_LEN - 4;

logic [2:0]  state;
logic [7:0]  cnt;       // Byte index within the current state
logic [31:0] crc;
logic [31:0] crc_next;
logic [7:0]  crc_data;

assign rd_en    = (state == st_payload);
assign crc_data = (state == st_payload) ? rd_data : 8'h00;  // Pad bytes are zero

eth_crc32 crc_i (
    .crc_in(crc),
    .data(crc_data),
    .crc_out(crc_next)
);

always_ff @(posedge clk) begin
    case (state)
        st_preamble: begin
            gmii_txd <= (cnt == 8'd7) ? 8'hd5 : 8'h55;
            crc      <= `ETH_CRC_INIT;
        end
        st_payload, st_pad: begin
            gmii_txd <= crc_data;
            crc      <= crc_next;
        end
        st_fcs: begin
            // FCS goes out inverted and least significant byte first
            gmii_txd <= ~crc[7:0];
            crc      <= {8'h00, crc[31:8]};
        end
        default: gmii_txd <= 8'h00;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        state      <= st_idle;
        cnt        <= 8'd0;
        gmii_tx_en <= 1'b0;
        gmii_tx_er <= 1'b0;
    end else begin
        gmii_tx_er <= 1'b0;  // This MAC never signals a transmit error
        case (state)
            st_idle: begin
                gmii_tx_en <= 1'b0;
                cnt        <= 8'd0;
                if (frame_ready) begin
                    state <= st_preamble;
                end
            end
            st_preamble: begin
                gmii_tx_en <= 1'b1;
                cnt        <= cnt + 8'd1;
                if (cnt == 8'd7) begin
                    state <= st_payload;
                    cnt   <= 8'd0;
                end
            end
            st_payload: begin
                gmii_tx_en <= 1'b1;
                if (cnt < 8'(min_payload)) begin
                    cnt <= cnt + 8'd1;  // Only counts far enough to decide on padding
                end
                if (rd_last) begin
                    if (cnt + 8'd1 >= 8'(min_payload)) begin
                        state <= st_fcs;
                        cnt   <= 8'd0;
                    end else begin
                        state <= st_pad;
                    end
                end
            end
            st_pad: begin
                gmii_tx_en <= 1'b1;
                cnt        <= cnt + 8'd1;
                if (cnt + 8'd1 >= 8'(min_payload)) begin
                    state <= st_fcs;
                    cnt   <= 8'd0;
                end
            end
            st_fcs: begin
                gmii_tx_en <= 1'b1;
                cnt        <= cnt + 8'd1;
                if (cnt == 8'd3) begin
                    state <= st_gap;
                    cnt   <= 8'd0;
                end
            end
            st_gap: begin
                gmii_tx_en <= 1'b0;
                cnt        <= cnt + 8'd1;
                if (cnt == 8'(`ETH_IFG_BYTES - 1)) begin
                    state <= st_idle;
                end
            end
            default: state <= st_idle;
        endcase
    end
end

endmodule

`default_nettype wire

// File: src/eth_loop_core.sv
// Top level of the GMII loopback, feeding received frames through the FIFO back to transmit
`default_nettype none
`include "eth_loop_macros.svh"

module eth_loop_core (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    output logic      [7:0] gmii_txd,
    output logic            gmii_tx_en,
    output logic            gmii_tx_er,
    output logic            rx_good_frame,
    output logic            rx_bad_frame,
    output logic            fifo_overflow
);

// Decoder to FIFO
logic [7:0]                  wr_data;
logic                        wr_en;
logic                        frame_end;
eth_loop_pkg::frame_status_e frame_status;

// FIFO to encoder
logic                        frame_ready;
logic [7:0]                  rd_data;
logic                        rd_last;
logic                        rd_en;

gmii_rx_decode rx_decode_i (
    .clk(clk),
    .reset(reset),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .wr_data(wr_data),
    .wr_en(wr_en),
    .frame_end(frame_end),
    .frame_status(frame_status),
    .rx_good_frame(rx_good_frame),
    .rx_bad_frame(rx_bad_frame)
);

frame_fifo #(
    .addr_w(`ETH_FIFO_ADDR_W)
) fifo_i (
    .clk(clk),
    .reset(reset),
    .wr_data(wr_data),
    .wr_en(wr_en),
    .frame_end(frame_end),
    .frame_status(frame_status),
    .frame_ready(frame_ready),
    .rd_data(rd_data),
    .rd_last(rd_last),
    .rd_en(rd_en),
    .fifo_overflow(fifo_overflow)
);

gmii_tx_encode tx_encode_i (
    .clk(clk),
    .reset(reset),
    .frame_ready(frame_ready),
    .rd_data(rd_data),
    .rd_last(rd_last),
    .rd_en(rd_en),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er)
);

endmodule

`default_nettype wire

// File: test/eth_loop_checker.sv
// Testbench monitor that compares transmitted frames and status pulses with the trace records
`default_nettype none
`include "eth_loop_macros.svh"

module eth_loop_checker (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] gmii_txd,
    input  wire logic       gmii_tx_en,
    input  wire logic       gmii_tx_er,
    input  wire logic       rx_good_frame,
    input  wire logic       rx_bad_frame,
    input  wire logic       fifo_overflow,
    input  wire logic       end_run,
    output logic            frames_done,
    output logic            counts_checked,
    output int              frames_checked,
    output int              error_count
);

logic [7:0] exp_bytes [$];   // Payload of every expected frame, back to back
int         exp_len [$];
logic [7:0] wire_bytes [$];  // Frame currently on the transmit pins
int         exp_offset;
int         exp_good;
int         exp_bad;
int         exp_overflow;
int         good_cnt;
int         bad_cnt;
int         overflow_cnt;
int         idle_cnt;
logic       in_tx;

// Whole byte folded into the register first, then one division step per shift
function automatic logic [31:0] crc_next_byte(logic [31:0] crc, logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    end
    return c;
endfunction

task automatic load_expected();
    int               fd;
    int               n;
    int               count;
    int               last;
    int               run_len;
    string            tag;
    logic [7:0]       first;
    logic [7:0]       step;
    logic [7:0]       b;
    logic [8*256-1:0] rest;
    run_len = 0;
    fd      = $fopen("test/eth_loop_trace.txt", "r");
    if (fd == 0) begin
        $display("Checker could not open the trace file test/eth_loop_trace.txt");
        error_count++;
    end else begin
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "E") begin
                n = $fscanf(fd, "%h %d %h %d", first, count, step, last);
                if (n != 4) begin
                    $display("Checker found a malformed expected frame record in the trace file");
                    error_count++;
                end else begin
                    b = first;
                    repeat (count) begin
                        exp_bytes.push_back(b);
                        b = b + step;
                    end
                    run_len += count;
                    if (last != 0) begin
                        exp_len.push_back(run_len);
                        run_len = 0;
                    end
                end
            end else if (tag == "C") begin
                n = $fscanf(fd, "%d %d %d", exp_good, exp_bad, exp_overflow);
                if (n != 3) begin
                    $display("Checker found a malformed status count record in the trace file");
                    error_count++;
                end
            end else begin
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    end
endtask

task automatic check_frame();
    logic [31:0] fcs;
    logic [7:0]  want;
    int          len;
    bit          mismatch;
    if (frames_checked >= exp_len.size()) begin
        $display("Unexpected frame of %0d bytes was transmitted at time %0t",
                 wire_bytes.size(), $time);
        error_count++;
    end else begin
        len      = exp_len[frames_checked];
        fcs      = 32'hffff_ffff;
        mismatch = 1'b0;
        for (int i = 0; i < len; i++) begin
            fcs = crc_next_byte(fcs, exp_bytes[exp_offset + i]);
        end
        fcs = ~fcs;
        if (wire_bytes.size() != len + 12) begin
            $display("[FAIL] %0t frame %0d has %0d bytes on the wire, expected %0d",
                     $time, frames_checked, wire_bytes.size(), len + 12);
            error_count++;
        end else begin
            for (int i = 0; i < len + 12; i++) begin
                if (i < 7) begin
                    want = 8'h55;
                end else if (i == 7) begin
                    want = 8'hd5;
                end else if (i < len + 8) begin
                    want = exp_bytes[exp_offset + i - 8];
                end else begin
                    want = fcs[8*(i-len-8) +: 8];  // FCS leaves LSB first
                end
                if (!mismatch && wire_bytes[i] !== want) begin
                    mismatch = 1'b1;
                    $display("[FAIL] %0t frame %0d byte %0d is %h, expected %h",
                             $time, frames_checked, i, wire_bytes[i], want);
                    error_count++;
                end
            end
        end
        exp_offset += len;
    end
    frames_checked++;
    if (frames_checked == exp_len.size()) begin
        frames_done = 1'b1;
    end
endtask

initial begin
    error_count    = 0;
    frames_checked = 0;
    frames_done    = 1'b0;
    counts_checked = 1'b0;
    exp_offset     = 0;
    exp_good       = 0;
    exp_bad        = 0;
    exp_overflow   = 0;
    good_cnt       = 0;
    bad_cnt        = 0;
    overflow_cnt   = 0;
    idle_cnt       = `ETH_IFG_BYTES;  // No gap is owed before the first frame
    in_tx          = 1'b0;
    load_expected();
    if (exp_len.size() == 0) begin
        frames_done = 1'b1;
    end
end

// Outputs change on the rising edge, so the falling edge sees them settled
always @(negedge clk) begin
    if (!reset) begin
        if (gmii_tx_er !== 1'b0) begin
            $display("[FAIL] %0t gmii_tx_er is %b, expected 0", $time, gmii_tx_er);
            error_count++;
        end
        if (rx_good_frame === 1'b1) begin
            good_cnt++;
        end
        if (rx_bad_frame === 1'b1) begin
            bad_cnt++;
        end
        if (fifo_overflow === 1'b1) begin
            overflow_cnt++;
        end
        if (gmii_tx_en === 1'b1) begin
            if (!in_tx && idle_cnt < `ETH_IFG_BYTES) begin
                $display("[FAIL] %0t frame started after %0d idle cycles, expected at least %0d",
                         $time, idle_cnt, `ETH_IFG_BYTES);
                error_count++;
            end
            in_tx = 1'b1;
            wire_bytes.push_back(gmii_txd);
        end else begin
            if (in_tx) begin
                check_frame();
                wire_bytes.delete();
                in_tx    = 1'b0;
                idle_cnt = 0;
            end
            idle_cnt++;
        end
        if (end_run && !counts_checked) begin
            if (good_cnt != exp_good) begin
                $display("[FAIL] %0t saw %0d rx_good_frame pulses, expected %0d",
                         $time, good_cnt, exp_good);
                error_count++;
            end
            if (bad_cnt != exp_bad) begin
                $display("[FAIL] %0t saw %0d rx_bad_frame pulses, expected %0d",
                         $time, bad_cnt, exp_bad);
                error_count++;
            end
            if (overflow_cnt != exp_overflow) begin
                $display("[FAIL] %0t saw %0d fifo_overflow pulses, expected %0d",
                         $time, overflow_cnt, exp_overflow);
                error_count++;
            end
            counts_checked = 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: test/eth_loop_tb.sv
// Testbench top for the GMII loopback, replays the receive trace into the DUT and ends the run
`default_nettype none

module eth_loop_tb;

logic       clk = 1'b0;
logic       reset;
logic [7:0] gmii_rxd;
logic       gmii_rx_dv;
logic       gmii_rx_er;
logic [7:0] gmii_txd;
logic       gmii_tx_en;
logic       gmii_tx_er;
logic       rx_good_frame;
logic       rx_bad_frame;
logic       fifo_overflow;
logic       end_run;
logic       frames_done;
logic       counts_checked;
int         frames_checked;
int         error_count;
int         cycle_cnt = 0;
int         timeout_limit = 0;  // Zero until the trace length is known
bit         trace_ok;

// Receive cycles expanded from the trace, one entry per clock
logic [7:0] rx_byte_q [$];
logic       rx_dv_q [$];
logic       rx_er_q [$];

always #20 clk = ~clk;

eth_loop_core dut_i (
    .clk(clk),
    .reset(reset),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er),
    .rx_good_frame(rx_good_frame),
    .rx_bad_frame(rx_bad_frame),
    .fifo_overflow(fifo_overflow)
);

eth_loop_checker checker_i (
    .clk(clk),
    .reset(reset),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er),
    .rx_good_frame(rx_good_frame),
    .rx_bad_frame(rx_bad_frame),
    .fifo_overflow(fifo_overflow),
    .end_run(end_run),
    .frames_done(frames_done),
    .counts_checked(counts_checked),
    .frames_checked(frames_checked),
    .error_count(error_count)
);

// Byte-wise reflected CRC-32 with the byte folded in before the shifts
function automatic logic [31:0] fcs_update(logic [31:0] crc, logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    end
    return c;
endfunction

task automatic push_cycle(logic dv, logic er, logic [7:0] b);
    rx_dv_q.push_back(dv);
    rx_er_q.push_back(er);
    rx_byte_q.push_back(b);
endtask

task automatic load_trace(output bit ok);
    int               fd;
    int               n;
    int               dv;
    int               er;
    int               count;
    int               bad;
    string            tag;
    logic [7:0]       first;
    logic [7:0]       step;
    logic [7:0]       b;
    logic [31:0]      crc;
    logic [31:0]      fcs;
    logic [8*256-1:0] rest;
    crc = 32'hffff_ffff;
    fd  = $fopen("test/eth_loop_trace.txt", "r");
    ok  = (fd != 0);
    if (ok) begin
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "P") begin
                repeat (7) push_cycle(1'b1, 1'b0, 8'h55);
                push_cycle(1'b1, 1'b0, 8'hd5);
                crc = 32'hffff_ffff;  // The FCS covers only the bytes after the delimiter
            end else if (tag == "R") begin
                n = $fscanf(fd, "%d %d %h %d %h", dv, er, first, count, step);
                if (n != 5) begin
                    ok = 1'b0;  // A short record would shift every later cycle
                end else begin
                    b = first;
                    repeat (count) begin
                        push_cycle(dv[0], er[0], b);
                        if (dv != 0) begin
                            crc = fcs_update(crc, b);
                        end
                        b = b + step;
                    end
                end
            end else if (tag == "F") begin
                n = $fscanf(fd, "%d", bad);
                if (n != 1) begin
                    ok = 1'b0;
                end else begin
                    fcs = ~crc;
                    if (bad != 0) begin
                        fcs[7:0] = ~fcs[7:0];
                    end
                    for (int k = 0; k < 4; k++) begin
                        push_cycle(1'b1, 1'b0, fcs[8*k +: 8]);  // Least significant byte first
                    end
                end
            end else begin
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    end
endtask

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
        $display("Run timed out after %0d cycles before all expected frames came out", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end
end

initial begin
    reset      = 1'b1;
    gmii_rxd   = 8'h00;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
    end_run    = 1'b0;
    load_trace(trace_ok);
    if (!trace_ok) begin
        $display("Could not open or parse the trace file test/eth_loop_trace.txt");
        $display("Simulation failed");
        $finish;
    end else begin
        timeout_limit = 8 * rx_byte_q.size() + 500;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (rx_byte_q[i]) begin
            @(posedge clk);
            gmii_rxd   <= rx_byte_q[i];
            gmii_rx_dv <= rx_dv_q[i];
            gmii_rx_er <= rx_er_q[i];
        end
        @(posedge clk);
        gmii_rxd   <= 8'h00;
        gmii_rx_dv <= 1'b0;
        gmii_rx_er <= 1'b0;
        wait (frames_done);
        // Quiet period so a stray frame or pulse still gets caught
        repeat (300) @(posedge clk);
        end_run <= 1'b1;
        wait (counts_checked);
        $display("Checked %0d frames with %0d errors", frames_checked, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
end

endmodule

`default_nettype wire

// File: test/eth_loop_trace.txt
# Tags: P = preamble and SFD, R dv er first count step = run of receive cycles (bytes in hex)
# F bad = four FCS bytes (bad 1 flips the first), E first count step last = expected payload run
# on the wire (last 1 closes the frame), C good bad overflow = expected status pulse counts
R 0 0 00 4 00
# Good 64-byte frame
P
R 1 0 00 60 01
F 0
R 0 0 00 12 00
# Short frame, padded to 60 bytes on transmit
P
R 1 0 a0 20 01
F 0
R 0 0 00 12 00
# Corrupted FCS, dropped
P
R 1 0 10 40 03
F 1
R 0 0 00 12 00
P
R 1 0 5a 30 00
F 0
R 0 0 00 12 00
# Receive error on one byte, dropped
P
R 1 0 33 10 01
R 1 1 3d 1 01
R 1 0 3e 19 01
F 0
R 0 0 00 12 00
# Three back-to-back frames at the minimum gap
P
R 1 0 80 64 01
F 0
R 0 0 00 12 00
P
R 1 0 01 100 07
F 0
R 0 0 00 12 00
P
R 1 0 ff 61 ff
F 0
R 0 0 00 12 00
# Longer than the FIFO, dropped with an overflow
P
R 1 0 00 2100 01
F 0
R 0 0 00 12 00
P
R 1 0 c3 50 05
F 0
R 0 0 00 12 00
# Expected frames in transmit order
E 00 60 01 1
E a0 20 01 0
E 00 40 00 1
E 5a 30 00 0
E 00 30 00 1
E 80 64 01 1
E 01 100 07 1
E ff 61 ff 1
E c3 50 05 0
E 00 10 00 1
C 8 2 1

// File: all.f
+incdir+src
src/eth_loop_pkg.sv
src/eth_crc32.sv
src/gmii_rx_decode.sv
src/frame_fifo.sv
src/gmii_tx_encode.sv
src/eth_loop_core.sv
test/eth_loop_checker.sv
test/eth_loop_tb.sv

// File: Bender.yml
package:
  name: eth_loop

sources:
  - include_dirs:
      - src
    files:
      - src/eth_loop_pkg.sv
      - src/eth_crc32.sv
      - src/gmii_rx_decode.sv
      - src/frame_fifo.sv
      - src/gmii_tx_encode.sv
      - src/eth_loop_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/eth_loop_checker.sv
      - test/eth_loop_tb.sv
